// ==== multdiv_cfg.svh ====
`ifndef MULTDIV_CFG_SVH
`define MULTDIV_CFG_SVH

// Operand and result width of the M extension.
`define MD_XLEN 32

// One multiplier half, fed to the 17x17 MAC with a sign bit on top.
`define MD_HALF 16

// Counts the 31 compare steps of the serial divider.
`define MD_CNT_W 5

`endif

// ==== multdiv_pkg.sv ====
`include "multdiv_cfg.svh"

package multdiv_pkg;

	typedef enum logic [1:0] {
		MD_OP_MULL = 2'd0,
		MD_OP_MULH = 2'd1,
		MD_OP_DIV  = 2'd2,
		MD_OP_REM  = 2'd3
	} md_op_e;

	typedef enum logic [1:0] {
		ALBL = 2'd0,
		ALBH = 2'd1,
		AHBL = 2'd2,
		AHBH = 2'd3
	} mult_state_e;

	typedef enum logic [2:0] {
		DIV_IDLE        = 3'd0,
		DIV_ABS_A       = 3'd1,
		DIV_ABS_B       = 3'd2,
		DIV_COMP        = 3'd3,
		DIV_LAST        = 3'd4,
		DIV_CHANGE_SIGN = 3'd5,
		DIV_FINISH      = 3'd6
	} div_state_e;

	typedef struct packed {
		md_op_e               op;
		logic [1:0]           signed_mode; // Bit 0 for op_a, bit 1 for op_b.
		logic [`MD_XLEN-1:0]  op_a;
		logic [`MD_XLEN-1:0]  op_b;
	} md_req_t;

endpackage

// ==== mult_mac16.sv ====
`timescale 1ns/1ps
`include "multdiv_cfg.svh"

module mult_mac16 (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  en_i,
	input  multdiv_pkg::md_req_t  req_i,
	output logic [`MD_XLEN-1:0]   result_o,
	output logic                  valid_o
);

	multdiv_pkg::mult_state_e state_q;
	multdiv_pkg::mult_state_e state_d;

	logic [2*`MD_HALF+1:0]          accum_q;
	logic [2*`MD_HALF+1:0]          accum_d;
	logic [2*`MD_HALF+1:0]          accum;
	logic [`MD_HALF-1:0]            mult_op_a;
	logic [`MD_HALF-1:0]            mult_op_b;
	logic                           sign_a;
	logic                           sign_b;
	logic signed [2*`MD_HALF+2:0]   mac_res_signed;
	logic [2*`MD_HALF+1:0]          mac_res;
	logic                           signed_mult;
	logic                           is_mull;
	logic                           mult_last;

	assign signed_mult = (req_i.signed_mode != 2'b00);
	assign is_mull     = (req_i.op == multdiv_pkg::MD_OP_MULL);

	// The one 17x17 signed multiply-accumulate.
	assign mac_res_signed = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b})
		+ $signed(accum);
	assign mac_res = mac_res_signed[2*`MD_HALF+1:0];

	always_comb begin
		mult_op_a = req_i.op_a[`MD_HALF-1:0];
		mult_op_b = req_i.op_b[`MD_HALF-1:0];
		sign_a    = 1'b0;
		sign_b    = 1'b0;
		accum     = accum_q;
		accum_d   = mac_res;
		state_d   = state_q;
		mult_last = 1'b0;

		case (state_q)
			multdiv_pkg::ALBL: begin
				accum   = '0;
				state_d = multdiv_pkg::ALBH;
			end

			multdiv_pkg::ALBH: begin
				mult_op_b = req_i.op_b[`MD_XLEN-1:`MD_HALF];
				sign_b    = req_i.signed_mode[1] & req_i.op_b[`MD_XLEN-1];
				accum     = {2'b00, {`MD_HALF{1'b0}}, accum_q[2*`MD_HALF-1:`MD_HALF]};
				if (is_mull) begin
					// Keep AL*BL low half.
					accum_d = {2'b00, mac_res[`MD_HALF-1:0], accum_q[`MD_HALF-1:0]};
				end
				state_d = multdiv_pkg::AHBL;
			end

			multdiv_pkg::AHBL: begin
				mult_op_a = req_i.op_a[`MD_XLEN-1:`MD_HALF];
				sign_a    = req_i.signed_mode[0] & req_i.op_a[`MD_XLEN-1];
				if (is_mull) begin
					accum     = {2'b00, {`MD_HALF{1'b0}}, accum_q[2*`MD_HALF-1:`MD_HALF]};
					accum_d   = {2'b00, mac_res[`MD_HALF-1:0], accum_q[`MD_HALF-1:0]};
					mult_last = 1'b1;
					state_d   = multdiv_pkg::ALBL;
				end else begin
					state_d = multdiv_pkg::AHBH; // Same weight as AL*BH, so no shift.
				end
			end

			multdiv_pkg::AHBH: begin
				mult_op_a = req_i.op_a[`MD_XLEN-1:`MD_HALF];
				mult_op_b = req_i.op_b[`MD_XLEN-1:`MD_HALF];
				sign_a    = req_i.signed_mode[0] & req_i.op_a[`MD_XLEN-1];
				sign_b    = req_i.signed_mode[1] & req_i.op_b[`MD_XLEN-1];
				accum     = {{`MD_HALF{signed_mult & accum_q[2*`MD_HALF+1]}},
					accum_q[2*`MD_HALF+1:`MD_HALF]};
				mult_last = 1'b1;
				state_d   = multdiv_pkg::ALBL;
			end

			default: begin
				state_d = multdiv_pkg::ALBL;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= multdiv_pkg::ALBL;
			accum_q <= '0;
		end else if (en_i) begin
			state_q <= state_d;
			accum_q <= accum_d;
		end
	end

	assign result_o = accum_d[`MD_XLEN-1:0];
	assign valid_o  = en_i & mult_last;

endmodule

// ==== div_serial.sv ====
`timescale 1ns/1ps
`include "multdiv_cfg.svh"

module div_serial (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  en_i,
	input  multdiv_pkg::md_req_t  req_i,
	output logic [`MD_XLEN-1:0]   result_o,
	output logic                  valid_o
);

	multdiv_pkg::div_state_e state_q;
	multdiv_pkg::div_state_e state_d;

	logic [`MD_CNT_W-1:0]  counter_q;
	logic [`MD_CNT_W-1:0]  counter_d;
	logic [`MD_XLEN-1:0]   numerator_q;
	logic [`MD_XLEN-1:0]   numerator_d;
	logic [`MD_XLEN-1:0]   denominator_q;
	logic [`MD_XLEN-1:0]   denominator_d;
	logic [`MD_XLEN-1:0]   quotient_q;
	logic [`MD_XLEN-1:0]   quotient_d;
	logic [`MD_XLEN-1:0]   remainder_q;
	logic [`MD_XLEN-1:0]   remainder_d;

	logic [`MD_XLEN:0]     add_a;
	logic [`MD_XLEN:0]     add_b;
	logic [`MD_XLEN:0]     add_sum;
	logic [`MD_XLEN-1:0]   add_res;
	logic [`MD_XLEN-1:0]   next_remainder;
	logic [`MD_XLEN-1:0]   next_quotient;
	logic [`MD_XLEN-1:0]   one_shift;
	logic                  is_greater_equal;
	logic                  div_by_zero;
	logic                  is_div;
	logic                  sign_a;
	logic                  sign_b;
	logic                  quot_change_sign;
	logic                  rem_change_sign;
	logic                  div_valid;

	// Both operands carry a forced one at bit 0, so a + ~b + 1 yields a - b.
	assign add_sum = add_a + add_b;
	assign add_res = add_sum[`MD_XLEN:1];

	assign div_by_zero      = (req_i.op_b == '0);
	assign is_div           = (req_i.op == multdiv_pkg::MD_OP_DIV);
	assign sign_a           = req_i.op_a[`MD_XLEN-1] & req_i.signed_mode[0];
	assign sign_b           = req_i.op_b[`MD_XLEN-1] & req_i.signed_mode[1];
	assign quot_change_sign = sign_a ^ sign_b;
	assign rem_change_sign  = sign_a; // The remainder follows the dividend.

	// Unsigned compare of the partial remainder against the divisor.
	always_comb begin
		if (remainder_q[`MD_XLEN-1] == denominator_q[`MD_XLEN-1]) begin
			is_greater_equal = ~add_res[`MD_XLEN-1];
		end else begin
			is_greater_equal = remainder_q[`MD_XLEN-1];
		end
	end

	assign one_shift      = {{(`MD_XLEN-1){1'b0}}, 1'b1} << counter_q;
	assign next_remainder = is_greater_equal ? add_res : remainder_q;
	assign next_quotient  = is_greater_equal ? (quotient_q | one_shift) : quotient_q;

	always_comb begin
		state_d       = state_q;
		counter_d     = counter_q - 1'b1;
		numerator_d   = numerator_q;
		denominator_d = denominator_q;
		quotient_d    = quotient_q;
		remainder_d   = remainder_q;
		add_a         = {{`MD_XLEN{1'b0}}, 1'b1};
		add_b         = {~req_i.op_b, 1'b1};
		div_valid     = 1'b0;

		case (state_q)
			multdiv_pkg::DIV_IDLE: begin
				remainder_d = is_div ? '1 : req_i.op_a; // Divide-by-zero results.
				counter_d   = '1;
				state_d     = div_by_zero ? multdiv_pkg::DIV_FINISH : multdiv_pkg::DIV_ABS_A;
			end

			multdiv_pkg::DIV_ABS_A: begin
				add_b       = {~req_i.op_a, 1'b1};
				quotient_d  = '0;
				numerator_d = sign_a ? add_res : req_i.op_a;
				counter_d   = '1;
				state_d     = multdiv_pkg::DIV_ABS_B;
			end

			multdiv_pkg::DIV_ABS_B: begin
				remainder_d   = {{(`MD_XLEN-1){1'b0}}, numerator_q[`MD_XLEN-1]};
				denominator_d = sign_b ? add_res : req_i.op_b;
				counter_d     = '1;
				state_d       = multdiv_pkg::DIV_COMP;
			end

			multdiv_pkg::DIV_COMP: begin
				add_a       = {remainder_q, 1'b1};
				add_b       = {~denominator_q, 1'b1};
				remainder_d = {next_remainder[`MD_XLEN-2:0], numerator_q[counter_d]};
				quotient_d  = next_quotient;
				if (counter_q == `MD_CNT_W'(1)) begin
					state_d = multdiv_pkg::DIV_LAST;
				end
			end

			multdiv_pkg::DIV_LAST: begin
				add_a       = {remainder_q, 1'b1};
				add_b       = {~denominator_q, 1'b1};
				remainder_d = is_div ? next_quotient : next_remainder;
				state_d     = multdiv_pkg::DIV_CHANGE_SIGN;
			end

			multdiv_pkg::DIV_CHANGE_SIGN: begin
				add_b = {~remainder_q, 1'b1};
				if (is_div ? quot_change_sign : rem_change_sign) begin
					remainder_d = add_res;
				end
				state_d = multdiv_pkg::DIV_FINISH;
			end

			multdiv_pkg::DIV_FINISH: begin
				div_valid = 1'b1;
				state_d   = multdiv_pkg::DIV_IDLE;
			end

			default: begin
				state_d = multdiv_pkg::DIV_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q       <= multdiv_pkg::DIV_IDLE;
			counter_q     <= '0;
			numerator_q   <= '0;
			denominator_q <= '0;
			quotient_q    <= '0;
			remainder_q   <= '0;
		end else if (en_i) begin
			state_q       <= state_d;
			counter_q     <= counter_d;
			numerator_q   <= numerator_d;
			denominator_q <= denominator_d;
			quotient_q    <= quotient_d;
			remainder_q   <= remainder_d;
		end
	end

	assign result_o = remainder_q;
	assign valid_o  = en_i & div_valid;

endmodule

// ==== multdiv_fast.sv ====
`timescale 1ns/1ps
`include "multdiv_cfg.svh"

module multdiv_fast (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  mult_en_i,
	input  logic                  div_en_i,
	input  multdiv_pkg::md_req_t  req_i,
	output logic [`MD_XLEN-1:0]   result_o,
	output logic                  valid_o
);

	logic [`MD_XLEN-1:0] mult_result;
	logic [`MD_XLEN-1:0] div_result;
	logic                mult_valid;
	logic                div_valid;

	mult_mac16 u_mult (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.en_i     (mult_en_i),
		.req_i    (req_i),
		.result_o (mult_result),
		.valid_o  (mult_valid)
	);

	div_serial u_div (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.en_i     (div_en_i),
		.req_i    (req_i),
		.result_o (div_result),
		.valid_o  (div_valid)
	);

	// Only one enable is high at a time, so the divider enable picks the source.
	assign result_o = div_en_i ? div_result : mult_result;
	assign valid_o  = mult_valid | div_valid;

endmodule

// ==== multdiv_fast_tb.sv ====
`timescale 1ns/1ps
`include "multdiv_cfg.svh"

module multdiv_fast_tb;

	localparam int CLK_PERIOD        = 20;
	localparam int RESET_CYCLES      = 5;
	localparam int CYCLES_PER_VECTOR = 45;

	logic                  clk_i;
	logic                  rst_ni;
	logic                  mult_en_i;
	logic                  div_en_i;
	multdiv_pkg::md_req_t  req_i;
	logic [`MD_XLEN-1:0]   result_o;
	logic                  valid_o;

	multdiv_pkg::md_req_t  vec_req[$];
	logic [`MD_XLEN-1:0]   vec_exp[$];
	int                    value_errors;
	int                    latency_errors;
	int                    other_errors;
	bit                    vectors_loaded;

	multdiv_fast u_multdiv_fast (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.mult_en_i (mult_en_i),
		.div_en_i  (div_en_i),
		.req_i     (req_i),
		.result_o  (result_o),
		.valid_o   (valid_o)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// Enabled cycles from the first enabled cycle up to and including the valid cycle.
	function automatic int expected_latency(input multdiv_pkg::md_req_t req);
		case (req.op)
			multdiv_pkg::MD_OP_MULL: return 3;
			multdiv_pkg::MD_OP_MULH: return 4;
			// 37 is 3 setup, 31 compare and 3 closing steps.
			default: return (req.op_b == '0) ? 2 : 37;
		endcase
	endfunction

	task automatic load_vectors();
		int                    fd;
		int                    code;
		string                 line;
		logic [`MD_XLEN-1:0]   op_val;
		logic [`MD_XLEN-1:0]   mode_val;
		logic [`MD_XLEN-1:0]   a_val;
		logic [`MD_XLEN-1:0]   b_val;
		logic [`MD_XLEN-1:0]   exp_val;
		multdiv_pkg::md_req_t  req;
		fd = $fopen("multdiv_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file multdiv_input.txt");
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
					code = $sscanf(line, "%h %h %h %h %h",
						op_val, mode_val, a_val, b_val, exp_val);
					if (code == 5) begin
						req.op          = multdiv_pkg::md_op_e'(op_val[1:0]);
						req.signed_mode = mode_val[1:0];
						req.op_a        = a_val;
						req.op_b        = b_val;
						vec_req.push_back(req);
						vec_exp.push_back(exp_val);
					end else begin
						$display("A line of the vector file could not be read: %s", line);
						other_errors++;
					end
				end
			end
			$fclose(fd);
			assert (vec_req.size() > 0) else begin
				$display("The vector file holds no vectors");
				other_errors++;
			end
		end
	endtask

	task automatic idle_gap(input int cycles);
		repeat (cycles) begin
			@(negedge clk_i);
			assert (!valid_o) else begin
				$display("valid_o was high in an idle cycle at %0t", $time);
				other_errors++;
			end
		end
	endtask

	// Holds the enable until valid_o is seen, then drops it at the next rising edge.
	task automatic run_request(input multdiv_pkg::md_req_t req,
		output logic [`MD_XLEN-1:0] result, output int cycles);
		bit seen;
		bit is_div;
		seen   = 1'b0;
		cycles = 0;
		result = '0;
		is_div = (req.op == multdiv_pkg::MD_OP_DIV) || (req.op == multdiv_pkg::MD_OP_REM);
		@(posedge clk_i);
		req_i     <= req;
		mult_en_i <= ~is_div;
		div_en_i  <= is_div;
		while (!seen) begin
			@(negedge clk_i);
			cycles++;
			if (valid_o) begin
				seen   = 1'b1;
				result = result_o;
			end
		end
		@(posedge clk_i);
		mult_en_i <= 1'b0;
		div_en_i  <= 1'b0;
	endtask

	task automatic check_result(input int idx, input logic [`MD_XLEN-1:0] result,
		input int cycles);
		int exp_cycles;
		exp_cycles = expected_latency(vec_req[idx]);
		assert (result == vec_exp[idx]) else begin
			$display(
				"CHECK FAILED result_o vector %0d op %0d mode %0d a %h b %h: expected %h, got %h",
				idx, vec_req[idx].op, vec_req[idx].signed_mode, vec_req[idx].op_a,
				vec_req[idx].op_b, vec_exp[idx], result);
			value_errors++;
		end
		assert (cycles == exp_cycles) else begin
			$display("Vector %0d: valid_o came after %0d enabled cycles instead of %0d",
				idx, cycles, exp_cycles);
			latency_errors++;
		end
	endtask

	task automatic print_counts();
		$display("Errors: %0d value, %0d latency, %0d other",
			value_errors, latency_errors, other_errors);
	endtask

	initial begin
		logic [`MD_XLEN-1:0] result;
		int                  cycles;
		int                  gap;
		clk_i          = 1'b0;
		rst_ni         = 1'b0;
		mult_en_i      = 1'b0;
		div_en_i       = 1'b0;
		req_i          = '0;
		value_errors   = 0;
		latency_errors = 0;
		other_errors   = 0;
		vectors_loaded = 1'b0;
		void'($urandom(84));
		load_vectors();
		vectors_loaded = 1'b1;

		repeat (RESET_CYCLES) begin
			@(negedge clk_i);
			assert (!valid_o) else begin
				$display("valid_o was high during reset at %0t", $time);
				other_errors++;
			end
		end
		@(posedge clk_i);
		rst_ni <= 1'b1;

		for (int i = 0; i < vec_req.size(); i++) begin
			gap = $urandom % 4 + 1;
			idle_gap(gap);
			run_request(vec_req[i], result, cycles);
			check_result(i, result, cycles);
		end
		idle_gap(2);

		print_counts();
		if (value_errors + latency_errors + other_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		longint timeout_ns;
		wait (vectors_loaded);
		timeout_ns = longint'(vec_req.size()) * CYCLES_PER_VECTOR * CLK_PERIOD + 1000;
		#(timeout_ns);
		$display("Timeout: the run did not finish within %0d ns", timeout_ns);
		print_counts();
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== multdiv_input.txt ====
# op mode op_a op_b expected, all in hex
# op is 0 MUL, 1 MULH, 2 DIV, 3 REM; mode bit 0 signs op_a, bit 1 signs op_b
0 0 00000003 00000007 00000015
2 0 00000064 00000007 0000000E
0 3 FFFFFFFF FFFFFFFF 00000001
3 0 00000064 00000007 00000002
0 1 FFFFFFFE 00000005 FFFFFFF6
2 3 FFFFFF9C 00000007 FFFFFFF2
0 3 80000000 00000002 00000000
3 3 FFFFFF9C 00000007 FFFFFFFE
0 0 0000FFFF 0000FFFF FFFE0001
2 3 00000064 FFFFFFF9 FFFFFFF2
0 0 00012345 00000100 01234500
3 3 00000064 FFFFFFF9 00000002
0 3 FFFF0000 00010001 FFFF0000
2 3 FFFFFF9C FFFFFFF9 0000000E
1 0 FFFFFFFF FFFFFFFF FFFFFFFE
3 3 FFFFFF9C FFFFFFF9 FFFFFFFE
1 3 FFFFFFFF FFFFFFFF 00000000
2 0 FFFFFFFF 00000010 0FFFFFFF
1 1 FFFFFFFF FFFFFFFF FFFFFFFF
3 0 FFFFFFFF 00000010 0000000F
1 2 FFFFFFFF FFFFFFFF FFFFFFFF
2 0 FFFFFF9C 00000007 24924916
1 3 80000000 80000000 40000000
3 0 FFFFFF9C 00000007 00000002
1 0 80000000 80000000 40000000
2 0 12345678 00000000 FFFFFFFF
1 3 80000000 00000002 FFFFFFFF
3 0 12345678 00000000 12345678
1 0 00010000 00010000 00000001
2 3 80000000 00000000 FFFFFFFF
1 3 7FFFFFFF 7FFFFFFF 3FFFFFFF
3 3 FFFFFF9C 00000000 FFFFFF9C
1 1 80000000 80000000 C0000000
2 3 80000000 FFFFFFFF 80000000
1 2 80000000 80000000 C0000000
3 3 80000000 FFFFFFFF 00000000
1 3 FFFFFFF0 00000100 FFFFFFFF
2 0 80000000 FFFFFFFF 00000000
1 0 0000FFFF FFFF0000 0000FFFE
3 0 80000000 FFFFFFFF 80000000

// ==== multdiv_fast.f ====
+incdir+.
multdiv_pkg.sv
mult_mac16.sv
div_serial.sv
multdiv_fast.sv
multdiv_fast_tb.sv

// ==== Makefile ====
TOP := multdiv_fast_tb
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f multdiv_fast.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -F -q '*** PASSED ***' $(LOG)

lint:
	verilator --lint-only -Wall --timing -f multdiv_fast.f --top-module multdiv_fast

clean:
	rm -rf obj_dir $(LOG)
